/* icache_top.f */
icache_pkg.sv
icache_way_ram.sv
icache_plru.sv
icache_refill.sv
icache_lookup.sv
icache_top.sv
tb_icache.sv

/* Makefile */
TOP       ?= tb_icache
RTL_TOP   ?= icache_top
FILELIST  ?= icache_top.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Result: PASSED
RTL_SRCS  ?= icache_pkg.sv icache_way_ram.sv icache_plru.sv icache_refill.sv \
             icache_lookup.sv icache_top.sv

.PHONY: run lint clean

run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

/* tb_icache.sv */
`timescale 1ns/1ps

module tb_icache import icache_pkg::*; ();

	localparam int RESET_CYCLES = 16;
	localparam int HIT_LAT = 3; // valid after edge N+2, taken at edge N+3
	localparam int REQS_MAX = 380; // all requests of all tests
	localparam int MISS_MAX = 32; // refill with request delay and beat gaps
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + SETS + REQS_MAX * MISS_MAX;

	logic i_clk = 1'b0;
	logic i_rst;
	logic i_req_valid;
	logic o_req_ready;
	addr_t i_req_addr;
	logic o_rsp_valid;
	logic i_rsp_ready;
	word_t o_rsp_data;
	logic o_mem_req_valid;
	logic i_mem_req_ready;
	mem_req_t o_mem_req;
	mem_beat_t i_mem_beat;

	logic [31:0] lcg_state = 32'd54;
	string cur_test = "reset";
	word_t exp_q[$];
	int acc_cyc_q[$];
	addr_t req_log[$]; // line addresses seen by the memory model
	int acc_count = 0;
	int rsp_count = 0;
	int cycle = 0;
	int timeout_cnt = 0;
	int test_err = 0;
	int err_total = 0;
	int tests_ok = 0;
	int tests_bad = 0;
	int max_out = 0;
	logic check_lat = 1'b0;
	logic rsp_random = 1'b0;
	logic rsp_hold = 1'b0;
	word_t rsp_held;

	icache_top dut0 (
		.i_clk           (i_clk),
		.i_rst           (i_rst),
		.i_req_valid     (i_req_valid),
		.o_req_ready     (o_req_ready),
		.i_req_addr      (i_req_addr),
		.o_rsp_valid     (o_rsp_valid),
		.i_rsp_ready     (i_rsp_ready),
		.o_rsp_data      (o_rsp_data),
		.o_mem_req_valid (o_mem_req_valid),
		.i_mem_req_ready (i_mem_req_ready),
		.o_mem_req       (o_mem_req),
		.i_mem_beat      (i_mem_beat)
	);

	always #20 i_clk = ~i_clk;

	// memory contents and expected data
	function automatic word_t ref_word(input addr_t addr);
		return (addr * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
	endfunction

	function automatic logic [31:0] rand_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 16; // low bits cycle quickly
	endfunction

	function automatic addr_t make_addr(input addr_t tag, input addr_t idx, input addr_t off);
		return (tag << (2 + OFFSET_W + INDEX_W)) | (idx << (2 + OFFSET_W)) | (off << 2);
	endfunction

	task automatic note_error();
		test_err++;
		err_total++;
	endtask

	task automatic compare_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
			note_error();
		end
	endtask

	task automatic expect_true(input logic ok, input string what);
		assert (ok) else begin
			$display("ERROR %s: %s", cur_test, what);
			note_error();
		end
	endtask

	// request and response handshakes
	always @(posedge i_clk) begin
		word_t want;
		int acc;
		cycle++;
		if (!i_rst) begin
			if (rsp_hold)
				expect_true(o_rsp_valid === 1'b1 && o_rsp_data === rsp_held,
					"response changed while stalled");
			if (o_rsp_valid && i_rsp_ready) begin
				if (exp_q.size() == 0) begin
					expect_true(1'b0, "response with no request outstanding");
				end else begin
					want = exp_q.pop_front();
					acc = acc_cyc_q.pop_front();
					compare_val("data", want, o_rsp_data);
					if (check_lat)
						compare_val("latency", HIT_LAT, cycle - acc);
				end
				rsp_count++;
			end
			if (i_req_valid && o_req_ready) begin
				exp_q.push_back(ref_word(i_req_addr));
				acc_cyc_q.push_back(cycle);
				acc_count++;
			end
			if (exp_q.size() > max_out)
				max_out = exp_q.size();
			rsp_hold = o_rsp_valid && !i_rsp_ready;
			rsp_held = o_rsp_data;
		end
	end

	initial begin : mem_model
		addr_t line;
		int gap;
		i_mem_req_ready = 1'b0;
		i_mem_beat = '0;
		forever begin
			@(negedge i_clk);
			if (o_mem_req_valid === 1'b1) begin
				gap = rand_next() % 4;
				repeat (gap) @(negedge i_clk);
				line = o_mem_req.line_addr;
				i_mem_req_ready = 1'b1;
				@(negedge i_clk);
				i_mem_req_ready = 1'b0;
				req_log.push_back(line);
				for (int b = 0; b < WORDS_PER_LINE; b++) begin
					i_mem_beat = '0;
					gap = rand_next() % 2;
					repeat (gap) @(negedge i_clk);
					i_mem_beat.valid = 1'b1;
					i_mem_beat.last = b == WORDS_PER_LINE - 1;
					i_mem_beat.data = ref_word(line + 4 * b); // word 0 first
					@(negedge i_clk);
				end
				i_mem_beat = '0;
			end
		end
	end

	initial begin : rsp_driver
		logic [31:0] r;
		i_rsp_ready = 1'b1;
		forever begin
			@(negedge i_clk);
			if (rsp_random) begin
				r = rand_next();
				i_rsp_ready = r[3];
			end else begin
				i_rsp_ready = 1'b1;
			end
		end
	end

	always @(posedge i_clk) begin
		timeout_cnt++;
		if (timeout_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles, stuck in test %s",
				TIMEOUT_CYCLES, cur_test);
			$display("Result: FAILED");
			$finish;
		end
	end

	// called on a falling edge, returns on the falling edge after acceptance
	task automatic send_req(input addr_t addr);
		int n;
		n = acc_count;
		i_req_valid = 1'b1;
		i_req_addr = addr;
		while (acc_count == n)
			@(negedge i_clk);
		i_req_valid = 1'b0;
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
			@(negedge i_clk);
	endtask

	task automatic read_word(input addr_t addr);
		send_req(addr);
		drain();
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_err = 0;
	endtask

	task automatic end_test();
		if (test_err == 0) begin
			tests_ok++;
			$display("test %s: ok", cur_test);
		end else begin
			tests_bad++;
			$display("test %s: %0d errors", cur_test, test_err);
		end
	endtask

	initial begin : stimulus
		int wait_cyc;
		int reqs0;
		int acc0;
		int rsp0;
		int off;
		logic [31:0] r;
		addr_t a0;
		addr_t a1;
		addr_t pl [5];

		i_rst = 1'b1;
		i_req_valid = 1'b0;
		i_req_addr = '0;
		a0 = 32'h0000_1040; // set 2
		a1 = 32'h0000_2060; // set 3

		start_test("reset_sweep");
		repeat (RESET_CYCLES) begin
			@(negedge i_clk);
			expect_true(o_req_ready !== 1'b1, "ready high during reset");
		end
		i_rst = 1'b0;
		wait_cyc = 0;
		while (o_req_ready !== 1'b1) begin
			@(negedge i_clk);
			wait_cyc++;
		end
		expect_true(wait_cyc >= SETS, "ready rose before the sweep could finish");
		compare_val("memory requests", 0, req_log.size());
		end_test();

		start_test("cold_miss");
		read_word(a0 + 12);
		compare_val("memory requests", 1, req_log.size());
		compare_val("line address", a0, req_log[0]);
		for (int w = 0; w < WORDS_PER_LINE; w++)
			if (w != 3)
				read_word(a0 + 4 * w);
		compare_val("memory requests", 1, req_log.size());
		end_test();

		start_test("pipelined_hits");
		reqs0 = req_log.size();
		max_out = 0;
		check_lat = 1'b1;
		for (int i = 0; i < 2 * WORDS_PER_LINE; i++)
			send_req(a0 + 4 * (i % WORDS_PER_LINE));
		drain();
		check_lat = 1'b0;
		expect_true(max_out >= 2, "fewer than two requests in flight");
		compare_val("memory requests", reqs0, req_log.size());
		end_test();

		start_test("rsp_backpressure");
		acc0 = acc_count;
		rsp0 = rsp_count;
		rsp_random = 1'b1;
		for (int i = 0; i < 40; i++) begin
			r = rand_next();
			off = r % 8;
			send_req((r[4] ? a1 : a0) + 4 * off);
		end
		drain();
		rsp_random = 1'b0;
		compare_val("responses", acc_count - acc0, rsp_count - rsp0);
		end_test();

		start_test("plru_replacement");
		for (int k = 0; k < 5; k++)
			pl[k] = make_addr(32'h100 + k, 20, 0);
		reqs0 = req_log.size();
		for (int k = 0; k < 4; k++)
			read_word(pl[k]); // ways 0, 2, 1, 3
		read_word(pl[0]); // tree now points at way 2, which holds pl[1]
		compare_val("requests after fills", reqs0 + 4, req_log.size());
		read_word(pl[4]);
		read_word(pl[0]);
		compare_val("requests after first line reread", reqs0 + 5, req_log.size());
		read_word(pl[1]);
		compare_val("requests after victim reread", reqs0 + 6, req_log.size());
		compare_val("victim line refetched", pl[1], req_log[req_log.size() - 1]);
		end_test();

		// six tags over four sets, so lines get evicted and refetched
		start_test("random_run");
		for (int i = 0; i < 300; i++) begin
			r = rand_next();
			send_req(make_addr(32'h200 + r % 6, 8 + (r >> 3) % 4, (r >> 5) % 8));
		end
		drain();
		end_test();

		$display("tests: %0d passed, %0d failed, %0d errors, %0d responses checked",
			tests_ok, tests_bad, err_total, rsp_count);
		if (err_total == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* icache_top.sv */
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_req_valid,
	output logic      o_req_ready,
	input  addr_t     i_req_addr,
	output logic      o_rsp_valid,
	input  logic      i_rsp_ready,
	output word_t     o_rsp_data,
	output logic      o_mem_req_valid,
	input  logic      i_mem_req_ready,
	output mem_req_t  o_mem_req,
	input  mem_beat_t i_mem_beat
);

	tag_entry_t [WAYS-1:0] way_tags;
	word_t [WAYS-1:0] way_data;
	logic rd_en;
	index_t rd_index;
	offset_t rd_offset;
	fill_wr_t wr;
	logic hit;
	index_t hit_index;
	way_t hit_way;
	logic miss;
	addr_t miss_addr;
	index_t victim_index;
	way_t victim_way;
	logic fill_start;
	way_t fill_way;
	logic fill_done;
	word_t fill_word;
	logic busy;

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		icache_way_ram u_way (
			.i_clk       (i_clk),
			.i_rst       (i_rst),
			.i_rd_en     (rd_en),
			.i_rd_index  (rd_index),
			.i_rd_offset (rd_offset),
			.i_wr_en     (wr.way_mask[w]),
			.i_wr        (wr),
			.o_tag       (way_tags[w]),
			.o_data      (way_data[w])
		);
	end

	icache_plru u_plru (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_hit          (hit),
		.i_hit_index    (hit_index),
		.i_hit_way      (hit_way),
		.i_fill         (fill_start),
		.i_fill_index   (victim_index),
		.i_fill_way     (fill_way),
		.i_victim_index (victim_index),
		.o_victim_way   (victim_way)
	);

	icache_refill u_refill (
		.i_clk           (i_clk),
		.i_rst           (i_rst),
		.i_miss          (miss),
		.i_miss_addr     (miss_addr),
		.i_victim_way    (victim_way),
		.o_victim_index  (victim_index),
		.o_mem_req_valid (o_mem_req_valid),
		.i_mem_req_ready (i_mem_req_ready),
		.o_mem_req       (o_mem_req),
		.i_mem_beat      (i_mem_beat),
		.o_wr            (wr),
		.o_fill_start    (fill_start),
		.o_fill_way      (fill_way),
		.o_fill_done     (fill_done),
		.o_fill_word     (fill_word),
		.o_busy          (busy)
	);

	icache_lookup u_lookup (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_req_valid (i_req_valid),
		.o_req_ready (o_req_ready),
		.i_req_addr  (i_req_addr),
		.o_rsp_valid (o_rsp_valid),
		.i_rsp_ready (i_rsp_ready),
		.o_rsp_data  (o_rsp_data),
		.i_busy      (busy),
		.o_rd_en     (rd_en),
		.o_rd_index  (rd_index),
		.o_rd_offset (rd_offset),
		.i_tags      (way_tags),
		.i_data      (way_data),
		.o_hit       (hit),
		.o_hit_index (hit_index),
		.o_hit_way   (hit_way),
		.o_miss      (miss),
		.o_miss_addr (miss_addr),
		.i_fill_done (fill_done),
		.i_fill_word (fill_word)
	);

endmodule

/* icache_lookup.sv */
`timescale 1ns/1ps

module icache_lookup import icache_pkg::*; (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_req_valid,
	output logic                  o_req_ready,
	input  addr_t                 i_req_addr,
	output logic                  o_rsp_valid,
	input  logic                  i_rsp_ready,
	output word_t                 o_rsp_data,
	input  logic                  i_busy,
	output logic                  o_rd_en,
	output index_t                o_rd_index,
	output offset_t               o_rd_offset,
	input  tag_entry_t [WAYS-1:0] i_tags,
	input  word_t [WAYS-1:0]      i_data,
	output logic                  o_hit,
	output index_t                o_hit_index,
	output way_t                  o_hit_way,
	output logic                  o_miss,
	output addr_t                 o_miss_addr,
	input  logic                  i_fill_done,
	input  word_t                 i_fill_word
);

	logic s1_valid;
	logic s2_valid;
	addr_t s1_addr;
	addr_t s2_addr;
	way_mask_t hit_vec;
	way_t hit_way;
	logic s2_hit;
	logic s2_miss;
	logic rsp_block;
	logic advance;

	always_comb begin
		hit_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			hit_vec[w] = i_tags[w].valid && i_tags[w].tag == addr_tag(s2_addr);
			if (hit_vec[w])
				hit_way = way_t'(w);
		end
	end

	assign s2_hit = s2_valid && |hit_vec;
	assign s2_miss = s2_valid && !(|hit_vec);
	assign rsp_block = o_rsp_valid && !i_rsp_ready;
	// a missed request leaves stage 2 only with the fill word
	assign advance = !rsp_block && !i_busy && (!s2_miss || i_fill_done);

	// arrays are read as stage 1 moves on, so a held address re-reads after a fill
	assign o_req_ready = advance;
	assign o_rd_en = advance && s1_valid;
	assign o_rd_index = addr_index(s1_addr);
	assign o_rd_offset = addr_offset(s1_addr);

	assign o_hit = s2_hit && advance;
	assign o_hit_index = addr_index(s2_addr);
	assign o_hit_way = hit_way;
	assign o_miss = s2_miss && !o_rsp_valid; // keeps the response slot free for the fill word
	assign o_miss_addr = s2_addr;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			o_rsp_valid <= 1'b0;
		end else if (advance) begin
			s1_valid <= i_req_valid;
			s2_valid <= s1_valid;
			o_rsp_valid <= s2_valid; // hit, or miss closed by the fill
		end else if (i_rsp_ready) begin
			o_rsp_valid <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (advance) begin
			s1_addr <= i_req_addr;
			s2_addr <= s1_addr;
			o_rsp_data <= i_fill_done ? i_fill_word : i_data[hit_way];
		end
	end

	a_one_hit: assert property (@(posedge i_clk) disable iff (i_rst)
		s2_valid |-> $onehot0(hit_vec));

endmodule

/* icache_refill.sv */
`timescale 1ns/1ps

module icache_refill import icache_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_miss,
	input  addr_t     i_miss_addr,
	input  way_t      i_victim_way,
	output index_t    o_victim_index,
	output logic      o_mem_req_valid,
	input  logic      i_mem_req_ready,
	output mem_req_t  o_mem_req,
	input  mem_beat_t i_mem_beat,
	output fill_wr_t  o_wr,
	output logic      o_fill_start,
	output way_t      o_fill_way,
	output logic      o_fill_done,
	output word_t     o_fill_word,
	output logic      o_busy
);

	refill_state_t state;
	refill_state_t state_nxt;
	index_t sweep_cnt;
	addr_t miss_addr; // held for the whole refill
	way_t fill_way;
	offset_t beat_cnt;
	logic beat_in;

	assign beat_in = state == RECEIVING && i_mem_beat.valid;
	assign o_victim_index = addr_index(i_miss_addr);
	// miss is still high in the done cycle
	assign o_fill_start = state == IDLE && i_miss && !o_fill_done;
	assign o_fill_way = i_victim_way;
	assign o_mem_req_valid = state == REQUEST;
	assign o_mem_req.line_addr = {miss_addr[31:OFFSET_W+2], {(OFFSET_W + 2){1'b0}}};
	assign o_busy = state != IDLE;

	always_comb begin
		state_nxt = state;
		case (state)
			INVALIDATING: begin
				if (sweep_cnt == index_t'(SETS - 1))
					state_nxt = IDLE;
			end
			IDLE: begin
				if (o_fill_start)
					state_nxt = REQUEST;
			end
			REQUEST: begin
				if (i_mem_req_ready)
					state_nxt = RECEIVING;
			end
			RECEIVING: begin
				if (beat_in && i_mem_beat.last)
					state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= INVALIDATING;
			sweep_cnt <= '0;
			beat_cnt <= '0;
			o_fill_done <= 1'b0;
		end else begin
			state <= state_nxt;
			o_fill_done <= beat_in && i_mem_beat.last; // lines up with the last write
			if (state == INVALIDATING)
				sweep_cnt <= sweep_cnt + 1'b1;
			if (o_fill_start)
				beat_cnt <= '0;
			else if (beat_in)
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_fill_start) begin
			miss_addr <= i_miss_addr;
			fill_way <= i_victim_way;
		end
		if (beat_in && beat_cnt == addr_offset(miss_addr))
			o_fill_word <= i_mem_beat.data; // critical word
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_wr.way_mask <= '0;
			o_wr.tag_we <= 1'b0;
		end else begin
			o_wr.way_mask <= '0;
			o_wr.tag_we <= 1'b0;
			if (state == INVALIDATING) begin
				o_wr.way_mask <= '1;
				o_wr.index <= sweep_cnt;
				o_wr.offset <= '0;
				o_wr.tag_we <= 1'b1;
				o_wr.tag_entry <= '0;
				o_wr.data <= '0;
			end else if (beat_in) begin
				o_wr.way_mask <= way_mask_t'(1) << fill_way;
				o_wr.index <= addr_index(miss_addr);
				o_wr.offset <= beat_cnt;
				o_wr.tag_we <= beat_cnt == '0;
				o_wr.tag_entry.valid <= 1'b1;
				o_wr.tag_entry.tag <= addr_tag(miss_addr);
				o_wr.data <= i_mem_beat.data;
			end
		end
	end

	a_beat_in_receiving: assert property (@(posedge i_clk) disable iff (i_rst)
		i_mem_beat.valid |-> state == RECEIVING);

	// the waiting request stays the line of the miss that the lookup holds
	a_req_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		o_mem_req_valid && !i_mem_req_ready |=> o_mem_req_valid && i_miss
			&& o_mem_req.line_addr[31:OFFSET_W+2] == i_miss_addr[31:OFFSET_W+2]);

endmodule

/* icache_plru.sv */
`timescale 1ns/1ps

module icache_plru import icache_pkg::*; (
	input  logic   i_clk,
	input  logic   i_rst,
	input  logic   i_hit,
	input  index_t i_hit_index,
	input  way_t   i_hit_way,
	input  logic   i_fill,
	input  index_t i_fill_index,
	input  way_t   i_fill_way,
	input  index_t i_victim_index,
	output way_t   o_victim_way
);

	plru_t tree [SETS];
	plru_t cur;
	logic upd;
	index_t upd_index;
	way_t upd_way;

	// bit 2 root, bit 1 ways 0/1, bit 0 ways 2/3
	function automatic plru_t touch(input plru_t old, input way_t way);
		plru_t nxt;
		nxt = old;
		nxt[2] = ~way[1]; // root to the other pair
		if (way[1])
			nxt[0] = ~way[0];
		else
			nxt[1] = ~way[0];
		return nxt;
	endfunction

	assign cur = tree[i_victim_index];
	assign o_victim_way = cur[2] ? {1'b1, cur[0]} : {1'b0, cur[1]};

	// a fill start and a hit never share a cycle
	assign upd = i_fill || i_hit;
	assign upd_index = i_fill ? i_fill_index : i_hit_index;
	assign upd_way = i_fill ? i_fill_way : i_hit_way;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int s = 0; s < SETS; s++)
				tree[s] <= '0;
		end else if (upd) begin
			tree[upd_index] <= touch(tree[upd_index], upd_way);
		end
	end

endmodule

/* icache_way_ram.sv */
`timescale 1ns/1ps

module icache_way_ram import icache_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst,
	input  logic       i_rd_en,
	input  index_t     i_rd_index,
	input  offset_t    i_rd_offset,
	input  logic       i_wr_en,
	input  fill_wr_t   i_wr,
	output tag_entry_t o_tag,
	output word_t      o_data
);

	tag_entry_t tag_mem [SETS];
	word_t data_mem [SETS][WORDS_PER_LINE];
	logic tag_fwd;
	logic data_fwd;

	// same edge write and read returns the new value
	assign tag_fwd = i_wr_en && i_wr.tag_we && i_wr.index == i_rd_index;
	assign data_fwd = i_wr_en && i_wr.index == i_rd_index && i_wr.offset == i_rd_offset;

	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			if (i_wr.tag_we)
				tag_mem[i_wr.index] <= i_wr.tag_entry;
			data_mem[i_wr.index][i_wr.offset] <= i_wr.data;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst)
			o_tag <= '0;
		else if (i_rd_en)
			o_tag <= tag_fwd ? i_wr.tag_entry : tag_mem[i_rd_index];
	end

	always_ff @(posedge i_clk) begin
		if (i_rd_en)
			o_data <= data_fwd ? i_wr.data : data_mem[i_rd_index][i_rd_offset];
	end

endmodule

/* icache_pkg.sv */
package icache_pkg;

	localparam int WAYS = 4;
	localparam int SETS = 64;
	localparam int WORDS_PER_LINE = 8;
	localparam int OFFSET_W = 3;
	localparam int INDEX_W = 6;
	localparam int TAG_W = 21; // 32 - index - word offset - byte bits
	localparam int PLRU_W = 3;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [OFFSET_W-1:0] offset_t;
	typedef logic [1:0] way_t;
	typedef logic [WAYS-1:0] way_mask_t;
	typedef logic [PLRU_W-1:0] plru_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

	typedef struct packed {
		addr_t line_addr; // offset bits always zero
	} mem_req_t;

	typedef struct packed {
		logic  valid;
		logic  last;
		word_t data;
	} mem_beat_t;

	typedef struct packed {
		way_mask_t  way_mask;
		index_t     index;
		offset_t    offset;
		logic       tag_we;
		tag_entry_t tag_entry;
		word_t      data;
	} fill_wr_t;

	typedef enum logic [1:0] {
		INVALIDATING,
		IDLE,
		REQUEST,
		RECEIVING
	} refill_state_t;

	function automatic tag_t addr_tag(input addr_t addr);
		return addr[31 -: TAG_W];
	endfunction

	function automatic index_t addr_index(input addr_t addr);
		return addr[2 + OFFSET_W +: INDEX_W];
	endfunction

	function automatic offset_t addr_offset(input addr_t addr);
		return addr[2 +: OFFSET_W];
	endfunction

endpackage
